//--- core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ----------------------------------------------------------
// Datapath and register file sizes.
// ----------------------------------------------------------
`define XLEN        64
`define REG_ADDR_W  5
`define NUM_REGS    32
`define INSTR_W     32

// ----------------------------------------------------------
// Major opcodes of the supported instruction groups.
// ----------------------------------------------------------
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// Funct3 encodings shared by OP and OP-IMM.
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

//--- core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // ----------------------------------------------------------
    // Instruction word views.
    // ----------------------------------------------------------

    // R-type layout.
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_view_t;

    // I-type layout.
    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_view_t;

    // Same 32-bit word, two decodings.
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    // ----------------------------------------------------------
    // Execution types.
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // One decoded operation.
    typedef struct packed {
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   use_imm;   // Immediate replaces rs2.
        logic [`XLEN-1:0]       imm;
        logic                   rs1_zero;  // Operand A forced to 0 for LUI.
    } dec_op_t;

    // One register writeback.
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decoder (
    input  logic              clk,
    input  logic              i_reset,
    input  core_pkg::instr_u  i_instr,
    input  logic              i_instr_valid,
    input  logic              i_wb_valid,
    output logic              o_instr_ready,
    output core_pkg::dec_op_t o_dec_op,
    output logic              o_dec_valid,
    output logic              o_illegal
);
    import core_pkg::*;

    logic                busy;
    logic                xfer;
    logic                legal;
    logic                is_shift;
    logic [`INSTR_W-1:0] instr_raw;
    dec_op_t             dec_next;

    // Maps funct3 and the alternate bit onto an ALU operation.
    function automatic alu_op_e pick_alu_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            `F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     op = ALU_SLL;
            `F3_SLT:     op = ALU_SLT;
            `F3_SLTU:    op = ALU_SLTU;
            `F3_XOR:     op = ALU_XOR;
            `F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    // Ready drops while an op is in flight or an illegal flag shows.
    assign o_instr_ready = ~(busy | o_illegal);
    assign xfer          = i_instr_valid & o_instr_ready;
    assign instr_raw     = i_instr;
    assign is_shift      = (i_instr.i.funct3 == `F3_SLL) || (i_instr.i.funct3 == `F3_SRL_SRA);

    // ----------------------------------------------------------
    // Decode.
    // ----------------------------------------------------------
    always_comb begin
        dec_next     = '0;
        dec_next.rd  = i_instr.r.rd;
        dec_next.rs1 = i_instr.r.rs1;
        dec_next.rs2 = i_instr.r.rs2;
        legal        = 1'b1;
        case (i_instr.r.opcode)
            `OPC_OP: begin
                dec_next.alu_op = pick_alu_op(i_instr.r.funct3, i_instr.r.funct7[5]);
            end
            `OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                // Only SRAI uses bit 30; ADDI never turns into a subtract.
                dec_next.alu_op  = pick_alu_op(i_instr.i.funct3,
                    (i_instr.i.funct3 == `F3_SRL_SRA) && i_instr.r.funct7[5]);
                if (is_shift) begin
                    dec_next.imm = {{(`XLEN-6){1'b0}}, i_instr.i.imm[5:0]};
                end else begin
                    dec_next.imm = {{(`XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
                end
            end
            `OPC_LUI: begin
                dec_next.alu_op   = ALU_PASS_B;
                dec_next.use_imm  = 1'b1;
                dec_next.rs1_zero = 1'b1;
                dec_next.imm      = {{(`XLEN-32){instr_raw[31]}}, instr_raw[31:12], 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Issue and busy tracking.
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy        <= 1'b0;
            o_dec_valid <= 1'b0;
            o_illegal   <= 1'b0;
        end else begin
            o_dec_valid <= xfer & legal;
            o_illegal   <= xfer & ~legal;
            if (xfer && legal) begin
                busy <= 1'b1;
            end else if (i_wb_valid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            o_dec_op <= dec_next;
        end
    end

endmodule

//--- operand_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module operand_stage (
    input  logic                   clk,
    input  logic                   i_reset,
    input  core_pkg::dec_op_t      i_dec_op,
    input  logic                   i_dec_valid,
    input  core_pkg::wb_t          i_wb,
    input  logic                   i_wb_valid,
    output logic [`XLEN-1:0]       o_op_a,
    output logic [`XLEN-1:0]       o_op_b,
    output logic [`REG_ADDR_W-1:0] o_rd,
    output core_pkg::alu_op_e      o_alu_op,
    output logic                   o_ex_valid
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    // ----------------------------------------------------------
    // Register file.
    // ----------------------------------------------------------
    assign rs1_data = regs[i_dec_op.rs1];
    assign rs2_data = regs[i_dec_op.rs2];

    // x0 is never written, so it keeps its reset value.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wb_valid && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // ----------------------------------------------------------
    // Operand registers.
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ex_valid <= 1'b0;
        end else begin
            o_ex_valid <= i_dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dec_valid) begin
            o_op_a   <= i_dec_op.rs1_zero ? '0 : rs1_data;
            o_op_b   <= i_dec_op.use_imm ? i_dec_op.imm : rs2_data;
            o_rd     <= i_dec_op.rd;
            o_alu_op <= i_dec_op.alu_op;
        end
    end

endmodule

//--- alu_exec.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module alu_exec (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic [`XLEN-1:0]       i_op_a,
    input  logic [`XLEN-1:0]       i_op_b,
    input  logic [`REG_ADDR_W-1:0] i_rd,
    input  core_pkg::alu_op_e      i_alu_op,
    input  logic                   i_ex_valid,
    output core_pkg::wb_t          o_wb,
    output logic                   o_wb_valid
);
    import core_pkg::*;

    logic [`XLEN-1:0] result;
    logic [5:0]       shamt;

    assign shamt = i_op_b[5:0];

    // ----------------------------------------------------------
    // ALU.
    // ----------------------------------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_ADD:    result = i_op_a + i_op_b;
            ALU_SUB:    result = i_op_a - i_op_b;
            ALU_SLL:    result = i_op_a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, ($signed(i_op_a) < $signed(i_op_b))};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, (i_op_a < i_op_b)};
            ALU_XOR:    result = i_op_a ^ i_op_b;
            ALU_SRL:    result = i_op_a >> shamt;
            ALU_SRA:    result = $signed(i_op_a) >>> shamt;
            ALU_OR:     result = i_op_a | i_op_b;
            ALU_AND:    result = i_op_a & i_op_b;
            ALU_PASS_B: result = i_op_b;
            default:    result = '0;
        endcase
    end

    // ----------------------------------------------------------
    // Writeback register.
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ex_valid) begin
            o_wb.rd   <= i_rd;
            o_wb.data <= result;
        end
    end

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_top (
    input  logic             clk,
    input  logic             i_reset,
    input  core_pkg::instr_u i_instr,
    input  logic             i_instr_valid,
    output logic             o_instr_ready,
    output logic             o_illegal,
    output core_pkg::wb_t    o_wb,
    output logic             o_wb_valid
);
    import core_pkg::*;

    // Decoder to operand stage.
    dec_op_t dec_op;
    logic    dec_valid;

    // Operand stage to ALU.
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`REG_ADDR_W-1:0] ex_rd;
    alu_op_e                alu_op;
    logic                   ex_valid;

    // ----------------------------------------------------------
    // Stages.
    // ----------------------------------------------------------
    instr_decoder decoder0 (
        .clk           ( clk           ),
        .i_reset       ( i_reset       ),
        .i_instr       ( i_instr       ),
        .i_instr_valid ( i_instr_valid ),
        .i_wb_valid    ( o_wb_valid    ),
        .o_instr_ready ( o_instr_ready ),
        .o_dec_op      ( dec_op        ),
        .o_dec_valid   ( dec_valid     ),
        .o_illegal     ( o_illegal     )
    );

    operand_stage operands0 (
        .clk         ( clk        ),
        .i_reset     ( i_reset    ),
        .i_dec_op    ( dec_op     ),
        .i_dec_valid ( dec_valid  ),
        .i_wb        ( o_wb       ),
        .i_wb_valid  ( o_wb_valid ),
        .o_op_a      ( op_a       ),
        .o_op_b      ( op_b       ),
        .o_rd        ( ex_rd      ),
        .o_alu_op    ( alu_op     ),
        .o_ex_valid  ( ex_valid   )
    );

    alu_exec exec0 (
        .clk        ( clk        ),
        .i_reset    ( i_reset    ),
        .i_op_a     ( op_a       ),
        .i_op_b     ( op_b       ),
        .i_rd       ( ex_rd      ),
        .i_alu_op   ( alu_op     ),
        .i_ex_valid ( ex_valid   ),
        .o_wb       ( o_wb       ),
        .o_wb_valid ( o_wb_valid )
    );

endmodule

//--- core_assert.sv
`timescale 1ns/1ps

module core_assert (
    input logic clk,
    input logic i_reset,
    input logic i_instr_valid,
    input logic i_instr_ready,
    input logic i_illegal,
    input logic i_wb_valid
);

    logic xfer;

    assign xfer = i_instr_valid & i_instr_ready;

    // Writeback lands three edges after its transfer.
    wb_after_xfer: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_valid |-> $past(xfer, 3))
        else $error("writeback without a transfer three cycles earlier");

    // ----------------------------------------------------------
    // Flags and reset.
    // ----------------------------------------------------------
    wb_not_illegal: assert property (@(posedge clk) disable iff (i_reset)
        !(i_wb_valid && i_illegal))
        else $error("writeback and illegal flag high together");

    ready_after_reset: assert property (@(posedge clk)
        $fell(i_reset) |-> i_instr_ready)
        else $error("instruction ready low right after reset");

endmodule

bind core_top core_assert assert0 (
    .clk           ( clk           ),
    .i_reset       ( i_reset       ),
    .i_instr_valid ( i_instr_valid ),
    .i_instr_ready ( o_instr_ready ),
    .i_illegal     ( o_illegal     ),
    .i_wb_valid    ( o_wb_valid    )
);

//--- core_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb;
    import core_pkg::*;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    typedef struct packed {
        logic [`INSTR_W-1:0]    instr;
        logic                   illegal;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } test_t;

    logic   clk;
    logic   i_reset;
    instr_u i_instr;
    logic   i_instr_valid;
    logic   o_instr_ready;
    logic   o_illegal;
    wb_t    o_wb;
    logic   o_wb_valid;
    test_t  tests[$];
    logic   table_loaded;
    int     n_pass;
    int     n_fail;

    core_top dut0 (
        .clk           ( clk           ),
        .i_reset       ( i_reset       ),
        .i_instr       ( i_instr       ),
        .i_instr_valid ( i_instr_valid ),
        .o_instr_ready ( o_instr_ready ),
        .o_illegal     ( o_illegal     ),
        .o_wb          ( o_wb          ),
        .o_wb_valid    ( o_wb_valid    )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Instruction encoders and table helpers.
    // ----------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input int rd);
        return {imm, rd[4:0], `OPC_LUI};
    endfunction

    function automatic void add_test(input logic [31:0] instr, input int rd,
                                     input logic [63:0] data);
        tests.push_back({instr, 1'b0, rd[4:0], data});
    endfunction

    function automatic void add_illegal(input logic [31:0] instr);
        tests.push_back({instr, 1'b1, 5'd0, 64'h0});
    endfunction

    // Expected values follow the RV64I rules in table order.
    task automatic load_table();
        // Untouched registers after reset.
        add_test(enc_r(F7_BASE, 2, 1, `F3_ADD_SUB, 3), 3, 64'h0);
        add_test(enc_r(F7_BASE, 31, 30, `F3_OR, 4), 4, 64'h0);
        // Constants from LUI and ADDI.
        add_test(enc_lui(20'h12345, 1), 1, 64'h0000_0000_1234_5000);
        add_test(enc_i(12'h678, 1, `F3_ADD_SUB, 1), 1, 64'h0000_0000_1234_5678);
        add_test(enc_lui(20'h80000, 2), 2, 64'hFFFF_FFFF_8000_0000);
        add_test(enc_i(12'hFFB, 0, `F3_ADD_SUB, 3), 3, 64'hFFFF_FFFF_FFFF_FFFB);
        add_test(enc_i(12'h7FF, 0, `F3_ADD_SUB, 4), 4, 64'h0000_0000_0000_07FF);
        // Register-register ops.
        add_test(enc_r(F7_BASE, 4, 1, `F3_ADD_SUB, 5), 5, 64'h0000_0000_1234_5E77);
        add_test(enc_r(F7_ALT, 1, 4, `F3_ADD_SUB, 6), 6, 64'hFFFF_FFFF_EDCB_B187);
        add_test(enc_r(F7_BASE, 4, 3, `F3_AND, 7), 7, 64'h0000_0000_0000_07FB);
        add_test(enc_r(F7_BASE, 2, 1, `F3_OR, 8), 8, 64'hFFFF_FFFF_9234_5678);
        add_test(enc_r(F7_BASE, 3, 1, `F3_XOR, 9), 9, 64'hFFFF_FFFF_EDCB_A983);
        // Signed and unsigned compares of -5 against 0x7FF.
        add_test(enc_r(F7_BASE, 4, 3, `F3_SLT, 10), 10, 64'h1);
        add_test(enc_r(F7_BASE, 4, 3, `F3_SLTU, 11), 11, 64'h0);
        add_test(enc_i(12'hFFC, 3, `F3_SLT, 12), 12, 64'h1);
        add_test(enc_i(12'hFFC, 3, `F3_SLTU, 13), 13, 64'h1);
        add_test(enc_i(12'h0FF, 1, `F3_AND, 14), 14, 64'h0000_0000_0000_0078);
        add_test(enc_i(12'h800, 4, `F3_OR, 15), 15, 64'hFFFF_FFFF_FFFF_FFFF);
        add_test(enc_i(12'hFFF, 1, `F3_XOR, 16), 16, 64'hFFFF_FFFF_EDCB_A987);
        // Shift amounts come from x17 (63) and from the low bits of x1 (56).
        add_test(enc_i(12'd63, 0, `F3_ADD_SUB, 17), 17, 64'd63);
        add_test(enc_r(F7_BASE, 17, 4, `F3_SLL, 18), 18, 64'h8000_0000_0000_0000);
        add_test(enc_r(F7_BASE, 17, 3, `F3_SRL_SRA, 19), 19, 64'h1);
        add_test(enc_r(F7_ALT, 17, 3, `F3_SRL_SRA, 20), 20, 64'hFFFF_FFFF_FFFF_FFFF);
        add_test(enc_r(F7_BASE, 1, 4, `F3_SLL, 21), 21, 64'hFF00_0000_0000_0000);
        add_test(enc_i(12'h020, 1, `F3_SLL, 22), 22, 64'h1234_5678_0000_0000);
        add_test(enc_i(12'h004, 2, `F3_SRL_SRA, 23), 23, 64'h0FFF_FFFF_F800_0000);
        add_test(enc_i(12'h404, 2, `F3_SRL_SRA, 24), 24, 64'hFFFF_FFFF_F800_0000);
        // Write to x0 is reported but not kept.
        add_test(enc_i(12'h005, 1, `F3_ADD_SUB, 0), 0, 64'h0000_0000_1234_567D);
        add_test(enc_r(F7_BASE, 4, 0, `F3_ADD_SUB, 25), 25, 64'h0000_0000_0000_07FF);
        // LD x5, 0(x1) and an all-ones word, then x5 read back.
        add_illegal({12'h000, 5'd1, 3'b011, 5'd5, 7'b0000011});
        add_illegal(32'hFFFF_FFFF);
        add_test(enc_r(F7_BASE, 0, 5, `F3_ADD_SUB, 26), 26, 64'h0000_0000_1234_5E77);
    endtask

    // ----------------------------------------------------------
    // One transfer and its response.
    // ----------------------------------------------------------
    task automatic run_test(input int idx, input test_t t);
        logic ok;
        ok = 1'b1;
        while (!o_instr_ready) begin
            @(negedge clk);
        end
        i_instr       = t.instr;
        i_instr_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        i_instr_valid = 1'b0;
        // Ready stays low until the response shows.
        while (!o_wb_valid && !o_illegal) begin
            if (o_instr_ready !== 1'b0) begin
                $display("MISMATCH at %0t: o_instr_ready got %0b, expected 0", $time,
                         o_instr_ready);
                ok = 1'b0;
            end
            @(negedge clk);
        end
        if (o_instr_ready !== 1'b0) begin
            $display("MISMATCH at %0t: o_instr_ready got %0b, expected 0", $time,
                     o_instr_ready);
            ok = 1'b0;
        end
        if (o_illegal !== t.illegal) begin
            $display("MISMATCH at %0t: o_illegal got %0b, expected %0b", $time, o_illegal,
                     t.illegal);
            ok = 1'b0;
        end
        if (!t.illegal && o_wb.rd !== t.rd) begin
            $display("MISMATCH at %0t: o_wb.rd got %0d, expected %0d", $time, o_wb.rd, t.rd);
            ok = 1'b0;
        end
        if (!t.illegal && o_wb.data !== t.data) begin
            $display("MISMATCH at %0t: o_wb.data got %h, expected %h", $time, o_wb.data,
                     t.data);
            ok = 1'b0;
        end
        // Ready returns one cycle after the response.
        @(negedge clk);
        if (o_instr_ready !== 1'b1) begin
            $display("MISMATCH at %0t: o_instr_ready got %0b, expected 1", $time,
                     o_instr_ready);
            ok = 1'b0;
        end
        if (o_wb_valid) begin
            $display("Writeback still high at %0t one cycle after the response", $time);
            ok = 1'b0;
        end
        // An illegal word must not be followed by a writeback.
        if (t.illegal) begin
            @(negedge clk);
            if (o_wb_valid) begin
                $display("Writeback seen at %0t after an illegal instruction", $time);
                ok = 1'b0;
            end
        end
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test %0d %s", idx, ok ? "passed" : "failed");
    endtask

    initial begin
        i_reset       = 1'b1;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        table_loaded  = 1'b0;
        n_pass        = 0;
        n_fail        = 0;
        load_table();
        table_loaded = 1'b1;
        repeat (8) @(negedge clk);
        i_reset = 1'b0;
        foreach (tests[k]) begin
            run_test(k, tests[k]);
        end
        $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        wait (table_loaded);
        repeat (tests.size() * 20 + 8) @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
core_pkg.sv
instr_decoder.sv
operand_stage.sv
alu_exec.sv
core_top.sv
core_assert.sv
core_tb.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/1ps
TOP      := core_tb
FLIST    := flist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
